//--- hw/xbar_pkg.sv
// Shared types and constants for the stream crossbar
// Data width is fixed here; destination sits in the low DST_W bits of a first beat
package xbar_pkg;

   localparam int DATA_W      = 64;
   localparam int DST_W       = 16;
   localparam int RB_DATA_W   = 32;   // Readback word and packet counters
   localparam int TABLE_DEPTH = 256;
   localparam int TBL_AW      = $clog2(TABLE_DEPTH);

   // Settings address pages relative to BASE
   localparam logic [7:0] LOCAL_PAGE  = 8'd0;   // BASE+0 .. BASE+255
   localparam logic [7:0] REMOTE_PAGE = 8'd1;   // BASE+256 .. BASE+511

   // One stream beat, valid/ready travel beside it
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } axis_beat_t;

   // Forwarding handshake of one ingress/egress pair
   typedef struct packed {
      logic req;   // From lookup
      logic ack;   // From egress arbiter
   } fwd_hs_t;

   typedef struct packed {
      logic        stb;
      logic [15:0] addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic       stb;
      logic [7:0] addr;   // Ingress field above egress field
   } rb_rd_t;

endpackage

//--- hw/fwd_cam.sv
`timescale 1ns/1ps
// Destination lookup for one ingress port. Table entries must hold an egress
// index below NUM_OUTPUTS; a larger value leaves the input stalled
module fwd_cam #(
   parameter  int NUM_OUTPUTS = 2,
   parameter  int BASE        = 0,
   localparam int EW          = (NUM_OUTPUTS > 1) ? $clog2(NUM_OUTPUTS) : 1
) (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  logic                              i_clear,
   input  logic [7:0]                        i_local_addr,
   // Monitored ingress stream
   input  xbar_pkg::axis_beat_t              i_beat,
   input  logic                              i_valid,
   input  logic                              i_ready,
   // Settings writes
   input  xbar_pkg::set_bus_t                i_set,
   // Forwarding handshake, one pair per egress
   output logic [NUM_OUTPUTS-1:0]            o_fwd_req,
   input  logic [NUM_OUTPUTS-1:0]            i_fwd_ack,
   // Counter readback
   input  logic                              i_rb_stb,
   input  logic [EW-1:0]                     i_rb_egress,
   output logic [xbar_pkg::RB_DATA_W-1:0]    o_rb_data
);

   localparam int HALF = xbar_pkg::DST_W / 2;

   logic [EW-1:0]                    local_tbl  [xbar_pkg::TABLE_DEPTH];
   logic [EW-1:0]                    remote_tbl [xbar_pkg::TABLE_DEPTH];
   logic [15:0]                      set_ofs;
   logic [xbar_pkg::DST_W-1:0]       dst;
   logic [EW-1:0]                    lookup_egr;
   logic [EW-1:0]                    egr_q;
   logic                             in_pkt;
   logic                             start;
   logic                             xfer_last;
   logic [xbar_pkg::RB_DATA_W-1:0]   pkt_cnt [NUM_OUTPUTS];

   // Offset from the settings base selects the page
   assign set_ofs = i_set.addr - 16'(BASE);

   always_ff @(posedge clk) begin
      if (i_set.stb) begin
         if (set_ofs[15:xbar_pkg::TBL_AW] == xbar_pkg::LOCAL_PAGE) begin
            local_tbl[set_ofs[xbar_pkg::TBL_AW-1:0]] <= i_set.data[EW-1:0];
         end
         if (set_ofs[15:xbar_pkg::TBL_AW] == xbar_pkg::REMOTE_PAGE) begin
            remote_tbl[set_ofs[xbar_pkg::TBL_AW-1:0]] <= i_set.data[EW-1:0];
         end
      end
   end

   assign dst = i_beat.data[xbar_pkg::DST_W-1:0];

   // Our own node: route on low byte, else on the node byte
   always_comb begin
      if (dst[xbar_pkg::DST_W-1:HALF] == i_local_addr) begin
         lookup_egr = local_tbl[dst[HALF-1:0]];
      end else begin
         lookup_egr = remote_tbl[dst[xbar_pkg::DST_W-1:HALF]];
      end
   end

   // Outside a packet every valid beat is a first beat.
   // Wait for the last ack to drop before asking again
   assign start     = !in_pkt && i_valid && (i_fwd_ack == '0);
   assign xfer_last = in_pkt && i_valid && i_ready && i_beat.last;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         in_pkt <= 1'b0;
      end else if (start) begin
         in_pkt <= 1'b1;
      end else if (xfer_last) begin
         in_pkt <= 1'b0;   // Req drops next cycle
      end
   end

   // Registered lookup result
   always_ff @(posedge clk) begin
      if (start) begin
         egr_q <= lookup_egr;
      end
   end

   always_comb begin
      o_fwd_req = '0;
      if (in_pkt) begin
         o_fwd_req[egr_q] = 1'b1;
      end
   end

   // Packets forwarded per egress
   always_ff @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         for (int k = 0; k < NUM_OUTPUTS; k++) begin
            pkt_cnt[k] <= '0;
         end
      end else if (xfer_last) begin
         pkt_cnt[egr_q] <= pkt_cnt[egr_q] + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rb_stb) begin
         o_rb_data <= pkt_cnt[i_rb_egress];
      end
   end

endmodule

//--- hw/out_arb_mux.sv
`timescale 1ns/1ps
// Round-robin arbiter and packet mux for one egress port.
// The data path is combinational while granted; a grant lasts the full handshake
module out_arb_mux #(
   parameter  int NUM_INPUTS = 2,
   localparam int IW         = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
) (
   input  logic                                   clk,
   input  logic                                   i_rst_n,
   input  logic                                   i_clear,
   // Forwarding handshake, one pair per ingress
   input  logic [NUM_INPUTS-1:0]                  i_fwd_req,
   output logic [NUM_INPUTS-1:0]                  o_fwd_ack,
   // Ingress streams
   input  xbar_pkg::axis_beat_t [NUM_INPUTS-1:0]  i_beats,
   input  logic [NUM_INPUTS-1:0]                  i_valid,
   output logic [NUM_INPUTS-1:0]                  o_ready_vec,
   // Egress stream
   output xbar_pkg::axis_beat_t                   o_beat,
   output logic                                   o_valid,
   input  logic                                   i_ready
);

   logic            busy;       // Ack is up for gnt_idx
   logic [IW-1:0]   gnt_idx;
   logic [IW-1:0]   ptr;        // Search start
   logic            pkt_done;   // Last beat gone, waiting for req to drop
   logic            release_gnt;
   logic            arb_en;
   logic            win_found;
   logic [IW-1:0]   win_idx;
   logic            pass;
   logic            xfer_last;

   assign release_gnt = busy && !i_fwd_req[gnt_idx];
   assign arb_en      = !busy || release_gnt;

   // First requester at or after ptr
   always_comb begin
      int cand;
      win_found = 1'b0;
      win_idx   = '0;
      for (int j = 0; j < NUM_INPUTS; j++) begin
         cand = int'(ptr) + j;
         if (cand >= NUM_INPUTS) begin
            cand = cand - NUM_INPUTS;
         end
         if (!win_found && i_fwd_req[cand]) begin
            win_found = 1'b1;
            win_idx   = IW'(cand);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         busy     <= 1'b0;
         gnt_idx  <= '0;
         pkt_done <= 1'b0;
      end else if (arb_en) begin
         // Old ack drops, a waiting input may take over in the same cycle
         busy     <= win_found;
         pkt_done <= 1'b0;
         if (win_found) begin
            gnt_idx <= win_idx;
         end
      end else if (xfer_last) begin
         pkt_done <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         ptr <= '0;
      end else if (arb_en && win_found) begin
         ptr <= (win_idx == IW'(NUM_INPUTS - 1)) ? '0 : win_idx + 1'b1;
      end
   end

   always_comb begin
      o_fwd_ack = '0;
      if (busy) begin
         o_fwd_ack[gnt_idx] = 1'b1;
      end
   end

   assign pass      = busy && !pkt_done;
   assign o_beat    = i_beats[gnt_idx];
   assign o_valid   = pass && i_valid[gnt_idx];
   assign xfer_last = o_valid && i_ready && o_beat.last;

   // Only the served input sees ready
   always_comb begin
      o_ready_vec = '0;
      if (pass) begin
         o_ready_vec[gnt_idx] = i_ready;
      end
   end

endmodule

//--- hw/axi_crossbar.sv
`timescale 1ns/1ps
// Packet crossbar with per-ingress lookup and per-egress round-robin arbiters.
// Readback addr holds egress index in low bits and ingress index above it; both must fit 8 bits
module axi_crossbar #(
   parameter int NUM_INPUTS  = 2,
   parameter int NUM_OUTPUTS = 2,
   parameter int BASE        = 0
) (
   input  logic                                    clk,
   input  logic                                    i_rst_n,
   input  logic                                    i_clear,
   input  logic [7:0]                              i_local_addr,
   // Ingress
   input  xbar_pkg::axis_beat_t [NUM_INPUTS-1:0]   i_beat,
   input  logic [NUM_INPUTS-1:0]                   i_valid,
   output logic [NUM_INPUTS-1:0]                   o_ready,
   // Egress
   output xbar_pkg::axis_beat_t [NUM_OUTPUTS-1:0]  o_beat,
   output logic [NUM_OUTPUTS-1:0]                  o_valid,
   input  logic [NUM_OUTPUTS-1:0]                  i_ready,
   // Settings and readback
   input  xbar_pkg::set_bus_t                      i_set,
   input  xbar_pkg::rb_rd_t                        i_rb,
   output logic [xbar_pkg::RB_DATA_W-1:0]          o_rb_data
);

   localparam int IW = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;
   localparam int EW = (NUM_OUTPUTS > 1) ? $clog2(NUM_OUTPUTS) : 1;

   xbar_pkg::fwd_hs_t                hs [NUM_INPUTS][NUM_OUTPUTS];   // Indexed [ingress][egress]
   logic [NUM_OUTPUTS-1:0]           cam_req [NUM_INPUTS];
   logic [NUM_OUTPUTS-1:0]           cam_ack [NUM_INPUTS];
   logic [NUM_INPUTS-1:0]            mux_req [NUM_OUTPUTS];
   logic [NUM_INPUTS-1:0]            mux_ack [NUM_OUTPUTS];
   logic [NUM_INPUTS-1:0]            rdy_vec [NUM_OUTPUTS];
   logic [xbar_pkg::RB_DATA_W-1:0]   cam_rb  [NUM_INPUTS];
   logic [IW-1:0]                    rb_in;
   logic [EW-1:0]                    rb_egr;
   logic [IW-1:0]                    rb_sel_q;

   assign rb_egr = i_rb.addr[EW-1:0];
   assign rb_in  = i_rb.addr[EW +: IW];

   // Swap between per-ingress and per-egress views of the handshake
   for (genvar n = 0; n < NUM_INPUTS; n++) begin : g_perm_in
      for (genvar m = 0; m < NUM_OUTPUTS; m++) begin : g_perm_out
         assign hs[n][m].req  = cam_req[n][m];
         assign hs[n][m].ack  = mux_ack[m][n];
         assign mux_req[m][n] = hs[n][m].req;
         assign cam_ack[n][m] = hs[n][m].ack;
      end
   end

   for (genvar n = 0; n < NUM_INPUTS; n++) begin : g_cam
      fwd_cam #(
         .NUM_OUTPUTS (NUM_OUTPUTS),
         .BASE        (BASE)
      ) u_cam (
         .clk          (clk),
         .i_rst_n      (i_rst_n),
         .i_clear      (i_clear),
         .i_local_addr (i_local_addr),
         .i_beat       (i_beat[n]),
         .i_valid      (i_valid[n]),
         .i_ready      (o_ready[n]),   // Folded ready marks transfers
         .i_set        (i_set),
         .o_fwd_req    (cam_req[n]),
         .i_fwd_ack    (cam_ack[n]),
         .i_rb_stb     (i_rb.stb && (rb_in == IW'(n))),
         .i_rb_egress  (rb_egr),
         .o_rb_data    (cam_rb[n])
      );
   end

   for (genvar m = 0; m < NUM_OUTPUTS; m++) begin : g_mux
      out_arb_mux #(
         .NUM_INPUTS (NUM_INPUTS)
      ) u_mux (
         .clk         (clk),
         .i_rst_n     (i_rst_n),
         .i_clear     (i_clear),
         .i_fwd_req   (mux_req[m]),
         .o_fwd_ack   (mux_ack[m]),
         .i_beats     (i_beat),
         .i_valid     (i_valid),
         .o_ready_vec (rdy_vec[m]),
         .o_beat      (o_beat[m]),
         .o_valid     (o_valid[m]),
         .i_ready     (i_ready[m])
      );
   end

   // At most one mux serves a given input
   always_comb begin
      o_ready = '0;
      for (int m = 0; m < NUM_OUTPUTS; m++) begin
         o_ready = o_ready | rdy_vec[m];
      end
   end

   // Cam word lands one cycle after stb, select follows it
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         rb_sel_q <= '0;
      end else if (i_rb.stb) begin
         rb_sel_q <= rb_in;
      end
   end

   assign o_rb_data = cam_rb[rb_sel_q];

endmodule

//--- test/axi_crossbar_sva.sv
`timescale 1ns/1ps
// Handshake and egress stream rules of the crossbar, bound into axi_crossbar.
// Nothing is checked while reset is low
module axi_crossbar_sva #(
   parameter int NUM_INPUTS  = 2,
   parameter int NUM_OUTPUTS = 2
) (
   input logic                                    clk,
   input logic                                    i_rst_n,
   input xbar_pkg::fwd_hs_t                       i_hs [NUM_INPUTS][NUM_OUTPUTS],
   input xbar_pkg::axis_beat_t [NUM_OUTPUTS-1:0]  i_egr_beat,
   input logic [NUM_OUTPUTS-1:0]                  i_egr_valid,
   input logic [NUM_OUTPUTS-1:0]                  i_egr_ready
);

   for (genvar n = 0; n < NUM_INPUTS; n++) begin : g_in
      for (genvar m = 0; m < NUM_OUTPUTS; m++) begin : g_out
         // Grant only answers a pending request
         a_ack_after_req: assert property (@(posedge clk) disable iff (!i_rst_n)
            $rose(i_hs[n][m].ack) |-> $past(i_hs[n][m].req))
            else $error("Ack of egress %0d to ingress %0d rose without req", m, n);

         a_req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
            $fell(i_hs[n][m].req) |-> $past(i_hs[n][m].ack))
            else $error("Req of ingress %0d to egress %0d fell before ack", n, m);
      end
   end

   for (genvar m = 0; m < NUM_OUTPUTS; m++) begin : g_egr
      a_egr_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
         (i_egr_valid[m] && !i_egr_ready[m]) |=> (i_egr_valid[m] && $stable(i_egr_beat[m])))
         else $error("Egress %0d dropped or changed a beat under back-pressure", m);
   end

endmodule

bind axi_crossbar axi_crossbar_sva #(
   .NUM_INPUTS  (NUM_INPUTS),
   .NUM_OUTPUTS (NUM_OUTPUTS)
) u_sva (
   .clk         (clk),
   .i_rst_n     (i_rst_n),
   .i_hs        (hs),
   .i_egr_beat  (o_beat),
   .i_egr_valid (o_valid),
   .i_egr_ready (i_ready)
);

//--- test/tb_axi_crossbar.sv
`timescale 1ns/1ps
// Testbench for a 2x2 crossbar. Rows name their egress by hand, so the table writes
// in write_tables and local_addr must stay in step with the row table
module tb_axi_crossbar;

   localparam int NI       = 2;
   localparam int NO       = 2;
   localparam int RB_EW    = $clog2(NO);   // Egress field of readback addr
   localparam int WAIT_MAX = 300;          // Cycles allowed per wait loop

   typedef struct packed {
      int          test;
      int          src;
      logic [15:0] dst;
      int          len;
      int          seed;
      int          egr;        // Expected egress
      bit          together;   // Starts with the next row
   } row_t;

   logic                                 clk;
   logic                                 rst_n;
   logic                                 clear;
   logic [7:0]                           local_addr;
   xbar_pkg::axis_beat_t [NI-1:0]        in_beat;
   logic [NI-1:0]                        in_valid;
   logic [NI-1:0]                        in_ready;
   xbar_pkg::axis_beat_t [NO-1:0]        out_beat;
   logic [NO-1:0]                        out_valid;
   logic [NO-1:0]                        out_ready;
   xbar_pkg::set_bus_t                   set_bus;
   xbar_pkg::rb_rd_t                     rb_req;
   logic [xbar_pkg::RB_DATA_W-1:0]       rb_data;

   row_t                  rows [$];
   xbar_pkg::axis_beat_t  exp_q [NO][$];
   int                    exp_cnt [NI][NO];
   int                    rr_ptr [NO];      // Model of each arbiter's search start
   int                    mon_err, mon_checks, chk_err, chk_checks;
   int                    tests_run, tests_failed, base_err;
   bit                    stalled;
   bit                    bp_en;

   axi_crossbar #(.NUM_INPUTS(NI), .NUM_OUTPUTS(NO), .BASE(0)) dut (
      .clk(clk), .i_rst_n(rst_n), .i_clear(clear), .i_local_addr(local_addr),
      .i_beat(in_beat), .i_valid(in_valid), .o_ready(in_ready),
      .o_beat(out_beat), .o_valid(out_valid), .i_ready(out_ready),
      .i_set(set_bus), .i_rb(rb_req), .o_rb_data(rb_data)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Egress ready, random on egress 1 during back-pressure
   initial begin
      void'($urandom(60665));
      out_ready = '1;
      forever begin
         @(posedge clk);
         #1;
         out_ready[0] = 1'b1;
         out_ready[1] = bp_en ? 1'($urandom % 2) : 1'b1;
      end
   end

   // Egress monitor, compares every transferred beat in arrival order
   always @(negedge clk) begin
      xbar_pkg::axis_beat_t exp_b;
      for (int m = 0; m < NO; m++) begin
         if (rst_n && out_valid[m] && out_ready[m]) begin
            mon_checks++;
            assert (exp_q[m].size() != 0) else begin
               $display("[ERROR] %0t: egress %0d sent a beat no packet expects", $time, m);
               mon_err++;
            end
            if (exp_q[m].size() != 0) begin
               exp_b = exp_q[m].pop_front();
               assert (out_beat[m] == exp_b) else begin
                  $display("[ERROR] %0t: egress %0d beat %h last %0b, expected %h last %0b",
                           $time, m, out_beat[m].data, out_beat[m].last, exp_b.data, exp_b.last);
                  mon_err++;
               end
            end
         end
      end
   end

   // Destination in the low 16 bits of beat 0 only
   function automatic logic [xbar_pkg::DATA_W-1:0] beat_data(row_t r, int k);
      logic [15:0] low;
      low = (k == 0) ? r.dst : 16'(r.seed ^ k);
      return {8'(r.src), 8'(r.seed), 16'(k), 16'(r.seed * 7 + k), low};
   endfunction

   // 0 when the first argument wins the round robin from ptr
   function automatic int first_served(int ptr, int sa, int sb);
      int c;
      for (int j = 0; j < NI; j++) begin
         c = (ptr + j) % NI;
         if (c == sa) return 0;
         if (c == sb) return 1;
      end
      return 0;
   endfunction

   task automatic add_row(int t, int s, logic [15:0] d, int l, int sd, int e, bit tog);
      rows.push_back(row_t'{t, s, d, l, sd, e, tog});
   endtask

   task automatic write_set(logic [15:0] addr, logic [31:0] data);
      @(posedge clk);
      #1;
      set_bus = '{stb: 1'b1, addr: addr, data: data};
      @(posedge clk);
      #1;
      set_bus.stb = 1'b0;
   endtask

   task automatic write_tables();
      write_set(16'h0010, 32'd1);   // Local 0x10
      write_set(16'h0020, 32'd0);
      write_set(16'h0133, 32'd0);   // Remote 0x33
      write_set(16'h0144, 32'd1);
   endtask

   task automatic push_expected(row_t r);
      xbar_pkg::axis_beat_t b;
      for (int k = 0; k < r.len; k++) begin
         b.data = beat_data(r, k);
         b.last = (k == r.len - 1);
         exp_q[r.egr].push_back(b);
      end
      exp_cnt[r.src][r.egr]++;
      rr_ptr[r.egr] = (r.src + 1) % NI;
   endtask

   task automatic send_pkt(row_t r);
      int cnt;
      @(posedge clk);
      #1;
      for (int k = 0; k < r.len; k++) begin
         in_beat[r.src].data = beat_data(r, k);
         in_beat[r.src].last = (k == r.len - 1);
         in_valid[r.src]     = 1'b1;
         cnt = 0;
         @(negedge clk);
         while (!in_ready[r.src] && cnt < WAIT_MAX) begin
            @(negedge clk);
            cnt++;
         end
         if (!in_ready[r.src]) begin
            $display("Input %0d saw no ready for beat %0d within %0d cycles", r.src, k, cnt);
            stalled = 1'b1;
            break;
         end
         @(posedge clk);
         #1;
      end
      in_valid[r.src] = 1'b0;
   endtask

   task automatic wait_drain();
      int cnt;
      cnt = 0;
      while ((exp_q[0].size() + exp_q[1].size()) != 0 && cnt < WAIT_MAX) begin
         @(negedge clk);
         cnt++;
      end
      if ((exp_q[0].size() + exp_q[1].size()) != 0) begin
         $display("Egress beats still missing after %0d cycles", cnt);
         stalled = 1'b1;
      end
   endtask

   task automatic run_rows(int t);
      int r;
      r = 0;
      while (r < rows.size() && !stalled) begin
         if (rows[r].test != t) begin
            r++;
         end else if (rows[r].together && r + 1 < rows.size()) begin
            // Arbiter order decides which packet the shared egress sees first
            if (rows[r].egr == rows[r+1].egr &&
                first_served(rr_ptr[rows[r].egr], rows[r].src, rows[r+1].src) == 1) begin
               push_expected(rows[r+1]);
               push_expected(rows[r]);
            end else begin
               push_expected(rows[r]);
               push_expected(rows[r+1]);
            end
            fork
               send_pkt(rows[r]);
               send_pkt(rows[r+1]);
            join
            wait_drain();
            r += 2;
         end else begin
            push_expected(rows[r]);
            send_pkt(rows[r]);
            wait_drain();
            r++;
         end
      end
   endtask

   task automatic check_counters();
      for (int n = 0; n < NI; n++) begin
         for (int m = 0; m < NO; m++) begin
            @(posedge clk);
            #1;
            rb_req.stb  = 1'b1;
            rb_req.addr = 8'((n << RB_EW) | m);
            @(posedge clk);
            #1;
            rb_req.stb = 1'b0;
            @(negedge clk);   // Word registered one cycle after stb
            chk_checks++;
            assert (rb_data == 32'(exp_cnt[n][m])) else begin
               $display("[ERROR] %0t: counter in %0d to out %0d reads %0d, expected %0d",
                        $time, n, m, rb_data, exp_cnt[n][m]);
               chk_err++;
            end
         end
      end
   endtask

   task automatic report_test(int t, string name);
      int errs;
      errs = mon_err + chk_err - base_err;
      tests_run++;
      if (errs == 0 && !stalled) begin
         $display("Test %0d %s: pass", t, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: FAIL, %0d errors", t, name, errs);
      end
      base_err = mon_err + chk_err;
   endtask

   initial begin
      rst_n      = 1'b0;
      clear      = 1'b0;
      local_addr = 8'h5A;
      in_beat    = '0;
      in_valid   = '0;
      set_bus    = '0;
      rb_req     = '0;
      bp_en      = 1'b0;
      stalled    = 1'b0;
      // test, src, dst, len, seed, egress, together
      add_row(1, 0, 16'h5A10, 4, 11, 1, 0);
      add_row(1, 1, 16'h5A20, 3, 12, 0, 0);
      add_row(1, 0, 16'h5A20, 1, 13, 0, 0);
      add_row(2, 0, 16'h3310, 5, 21, 0, 0);   // Local entry 0x10 would give 1
      add_row(2, 0, 16'h4420, 2, 22, 1, 0);
      add_row(2, 1, 16'h4455, 3, 23, 1, 0);
      add_row(3, 0, 16'h5A10, 4, 31, 1, 1);
      add_row(3, 1, 16'h4420, 3, 32, 1, 0);
      add_row(3, 1, 16'h3301, 2, 33, 0, 1);
      add_row(3, 0, 16'h5A20, 5, 34, 0, 0);
      add_row(4, 0, 16'h5A10, 6, 41, 1, 1);
      add_row(4, 1, 16'h3322, 4, 42, 0, 0);
      add_row(4, 1, 16'h4400, 5, 43, 1, 0);
      add_row(4, 0, 16'h4412, 3, 44, 1, 0);
      add_row(5, 1, 16'h5A10, 3, 51, 1, 0);
      add_row(5, 0, 16'h3344, 2, 52, 0, 0);
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      chk_checks++;
      assert (out_valid == '0 && in_ready == '0) else begin
         $display("[ERROR] %0t: valid or ready high after reset", $time);
         chk_err++;
      end
      write_tables();
      run_rows(1);
      report_test(1, "local routing");
      run_rows(2);
      report_test(2, "remote routing");
      run_rows(3);
      report_test(3, "contention");
      bp_en = 1'b1;
      run_rows(4);
      bp_en = 1'b0;
      report_test(4, "back-pressure");
      check_counters();
      @(posedge clk);
      #1;
      clear = 1'b1;
      @(posedge clk);
      #1;
      clear = 1'b0;
      foreach (exp_cnt[n, m]) exp_cnt[n][m] = 0;
      foreach (rr_ptr[m]) rr_ptr[m] = 0;
      check_counters();
      run_rows(5);   // Tables survive the clear
      check_counters();
      report_test(5, "readback and clear");
      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, mon_checks + chk_checks, mon_err + chk_err);
      if (tests_failed == 0 && mon_err + chk_err == 0 && !stalled) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- flist.f
hw/xbar_pkg.sv
hw/fwd_cam.sv
hw/out_arb_mux.sv
hw/axi_crossbar.sv
test/axi_crossbar_sva.sv
test/tb_axi_crossbar.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the crossbar testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_axi_crossbar -Mdir "$BUILD_DIR" -o sim_tb -f flist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./"$BUILD_DIR"/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
